// File: Bender.yml
package:
  name: pin_bus_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/pin_bus_pkg.sv
      - logic/beat_counter.sv
      - logic/lane_serializer.sv
      - logic/lane_deserializer.sv
      - logic/bridge_fsm.sv
      - logic/pin_bus_bridge.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/pin_bus_bridge_assertions.sv
      - testbench/pin_bus_bridge_tb.sv

// File: logic/beat_counter.sv
`default_nettype none

`include "pin_bus_consts.svh"

module beat_counter (
  input  logic clk,
  input  logic rst,
  input  logic cnt_load,
  output logic cnt_last
);

  logic [`PIN_BUS_CNT_W-1:0] cnt;  // Beats left in the phase after this one

  // Zero means the current beat closes the phase
  assign cnt_last = (cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (cnt_load) begin
      cnt <= `PIN_BUS_CNT_W'(`PIN_BUS_BEATS - 1);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;  // Holds at zero between phases
    end
  end

endmodule

`default_nettype wire

// File: logic/bridge_fsm.sv
`default_nettype none

module bridge_fsm (
  input  logic       clk,
  input  logic       rst,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [1:0] addr_offset,
  input  logic       cnt_last,
  output logic       cnt_load,
  output logic       ser_load,
  output logic       ser_shift,
  output logic       capture,
  output logic       pin_strobe,
  output logic       pin_rw,
  output logic       pin_oe,
  output logic       pready,
  output logic       pslverr
);

  import pin_bus_pkg::*;

  bridge_state_t state;
  bridge_state_t next_state;

  logic accept;      // APB access phase seen while idle
  logic frame_next;  // Next cycle is a pin beat
  logic rw_next;     // Direction for the next cycle

  assign accept = (state == IDLE) && psel && penable;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          if (addr_offset != 2'b00) begin
            next_state = ERR;  // Unaligned, no pin activity
          end else begin
            next_state = ADDR;
          end
        end
      end
      ADDR: begin
        if (cnt_last) begin
          next_state = pin_rw ? DONE : RDATA;
        end
      end
      RDATA: begin
        if (cnt_last) begin
          next_state = DONE;
        end
      end
      DONE: next_state = IDLE;
      ERR: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // Lanes and counter start on acceptance of an aligned request
  assign ser_load  = accept && (addr_offset == 2'b00);
  assign ser_shift = (state == ADDR);
  assign capture   = (state == RDATA);

  // Counter restarts for the first phase and again for the read beats
  assign cnt_load = ser_load || ((state == ADDR) && cnt_last && !pin_rw);

  assign frame_next = (next_state == ADDR) || (next_state == RDATA);

  always_comb begin
    if (ser_load) begin
      rw_next = pwrite;  // Direction is latched for the whole frame
    end else if (frame_next) begin
      rw_next = pin_rw;
    end else begin
      rw_next = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      pin_strobe <= 1'b0;
      pin_rw     <= 1'b0;
      pin_oe     <= 1'b0;
      pready     <= 1'b0;
      pslverr    <= 1'b0;
    end else begin
      state      <= next_state;
      pin_strobe <= frame_next;
      pin_rw     <= rw_next;
      pin_oe     <= (next_state == ADDR) && rw_next;  // Write beats only
      pready     <= (next_state == DONE) || (next_state == ERR);
      pslverr    <= (next_state == ERR);
    end
  end

endmodule

`default_nettype wire

// File: logic/lane_deserializer.sv
`default_nettype none

`include "pin_bus_consts.svh"

module lane_deserializer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       capture,
  input  logic [`PIN_BUS_LANE_W-1:0] lane,
  output pin_bus_pkg::bus_word_t     word
);

  // New bytes enter at the top and walk down, so the first
  // byte of the frame ends up in the least significant lane
  always_ff @(posedge clk) begin
    if (rst) begin
      word <= '0;
    end else if (capture) begin
      word <= {lane, word[`PIN_BUS_WORD_W-1:`PIN_BUS_LANE_W]};
    end
  end

endmodule

`default_nettype wire

// File: logic/lane_serializer.sv
`default_nettype none

`include "pin_bus_consts.svh"

module lane_serializer #(
  parameter type payload_t = pin_bus_pkg::bus_word_t
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load,
  input  logic                       shift,
  input  payload_t                   payload,
  output logic [`PIN_BUS_LANE_W-1:0] lane
);

  localparam int payload_w = $bits(payload_t);

  logic [payload_w-1:0] payload_bits;  // Payload viewed as a flat vector
  logic [payload_w-1:0] rest;          // Bytes still waiting for the lane

  assign payload_bits = payload;

  // Each shift pulls zeros in from the top, so the lane
  // drops to zero once the last byte has gone out
  always_ff @(posedge clk) begin
    if (rst) begin
      lane <= '0;
      rest <= '0;
    end else if (load) begin
      lane <= payload_bits[`PIN_BUS_LANE_W-1:0];  // Low byte first
      rest <= payload_bits >> `PIN_BUS_LANE_W;
    end else if (shift) begin
      lane <= rest[`PIN_BUS_LANE_W-1:0];
      rest <= rest >> `PIN_BUS_LANE_W;
    end
  end

endmodule

`default_nettype wire

// File: logic/pin_bus_bridge.sv
`default_nettype none

`include "pin_bus_consts.svh"

module pin_bus_bridge (
  input  logic                       clk,
  input  logic                       rst,
  // APB completer port
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  pin_bus_pkg::bus_addr_t     paddr,
  input  pin_bus_pkg::bus_word_t     pwdata,
  output logic                       pready,
  output pin_bus_pkg::bus_word_t     prdata,
  output logic                       pslverr,
  // External device pins
  output logic [`PIN_BUS_LANE_W-1:0] pin_addr,
  output logic [`PIN_BUS_LANE_W-1:0] pin_wdata,
  input  logic [`PIN_BUS_LANE_W-1:0] pin_rdata,
  output logic                       pin_strobe,
  output logic                       pin_rw,
  output logic                       pin_oe
);

  import pin_bus_pkg::*;

  logic cnt_load;   // Restart the beat counter
  logic cnt_last;   // Final beat of a phase
  logic ser_load;   // Capture address and write data
  logic ser_shift;  // Next byte onto the output lanes
  logic capture;    // Sample the read lane

  bridge_fsm i_bridge_fsm (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .addr_offset (paddr.byte_off),
    .cnt_last    (cnt_last),
    .cnt_load    (cnt_load),
    .ser_load    (ser_load),
    .ser_shift   (ser_shift),
    .capture     (capture),
    .pin_strobe  (pin_strobe),
    .pin_rw      (pin_rw),
    .pin_oe      (pin_oe),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  beat_counter i_beat_counter (
    .clk      (clk),
    .rst      (rst),
    .cnt_load (cnt_load),
    .cnt_last (cnt_last)
  );

  // Address goes out on every frame
  lane_serializer #(
    .payload_t (bus_addr_t)
  ) i_addr_lane (
    .clk     (clk),
    .rst     (rst),
    .load    (ser_load),
    .shift   (ser_shift),
    .payload (paddr),
    .lane    (pin_addr)
  );

  // Write data lane, only qualified by pin_oe
  lane_serializer #(
    .payload_t (bus_word_t)
  ) i_wdata_lane (
    .clk     (clk),
    .rst     (rst),
    .load    (ser_load),
    .shift   (ser_shift),
    .payload (pwdata),
    .lane    (pin_wdata)
  );

  lane_deserializer i_rdata_lane (
    .clk     (clk),
    .rst     (rst),
    .capture (capture),
    .lane    (pin_rdata),
    .word    (prdata)  // Valid when pready rises on a read
  );

endmodule

`default_nettype wire

// File: logic/pin_bus_consts.svh
`ifndef PIN_BUS_CONSTS_SVH
`define PIN_BUS_CONSTS_SVH

// Width of one pin lane, one byte per beat
`define PIN_BUS_LANE_W 8

// Width of an APB data word and address
`define PIN_BUS_WORD_W 32

// Beats needed to move one word over a lane
`define PIN_BUS_BEATS 4

// Width of the beat counter
`define PIN_BUS_CNT_W 3

`endif

// File: logic/pin_bus_pkg.sv
`default_nettype none

`include "pin_bus_consts.svh"

package pin_bus_pkg;

  // Byte address split into word index and byte offset
  typedef struct packed {
    logic [`PIN_BUS_WORD_W-3:0] word_idx;  // Word address
    logic [1:0]                 byte_off;  // Must be zero for a legal access
  } bus_addr_t;

  // One data word as seen on the APB port
  typedef logic [`PIN_BUS_WORD_W-1:0] bus_word_t;

  // Bridge sequencing states
  typedef enum logic [2:0] {
    IDLE,   // Waiting for an APB access phase
    ADDR,   // Address beats, plus write data on a write
    RDATA,  // Read beats from the device
    DONE,   // One cycle of pready
    ERR     // One cycle of pready with pslverr
  } bridge_state_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+logic
logic/pin_bus_pkg.sv
logic/beat_counter.sv
logic/lane_serializer.sv
logic/lane_deserializer.sv
logic/bridge_fsm.sv
logic/pin_bus_bridge.sv
testbench/pin_bus_bridge_assertions.sv
testbench/pin_bus_bridge_tb.sv

// File: testbench/pin_bus_bridge_assertions.sv
`default_nettype none

module pin_bus_bridge_assertions (
  input logic clk,
  input logic rst,
  input logic pin_strobe,
  input logic pin_rw,
  input logic pin_oe,
  input logic pready
);

  int unsigned fail_count = 0;  // Read by the testbench at the end of the run

  // Output enable belongs to write beats only
  oe_on_write_beat: assert property (
    @(posedge clk) disable iff (rst)
    pin_oe |-> (pin_strobe && pin_rw)
  ) else begin
    $error("pin_oe high outside a write beat");
    fail_count++;
  end

  pready_single_cycle: assert property (
    @(posedge clk) disable iff (rst)
    pready |=> !pready
  ) else begin
    $error("pready held for more than one cycle");
    fail_count++;
  end

  // Direction may not change inside a frame
  rw_stable_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    pin_strobe ##1 pin_strobe |-> $stable(pin_rw)
  ) else begin
    $error("pin_rw changed while pin_strobe stayed high");
    fail_count++;
  end

endmodule

bind pin_bus_bridge pin_bus_bridge_assertions i_pin_bus_bridge_assertions (
  .clk        (clk),
  .rst        (rst),
  .pin_strobe (pin_strobe),
  .pin_rw     (pin_rw),
  .pin_oe     (pin_oe),
  .pready     (pready)
);

`default_nettype wire

// File: testbench/pin_bus_bridge_tb.sv
`default_nettype none

`include "pin_bus_consts.svh"

module pin_bus_bridge_tb;

  import pin_bus_pkg::*;

  localparam int beats          = `PIN_BUS_BEATS;
  localparam int lane_w         = `PIN_BUS_LANE_W;
  localparam int timeout_cycles = 2000;  // About ten times the whole test run
  localparam int wait_limit     = 40;    // Longest wait for pready

  logic              clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  bus_addr_t         paddr;
  bus_word_t         pwdata;
  logic              pready;
  bus_word_t         prdata;
  logic              pslverr;
  logic [lane_w-1:0] pin_addr;
  logic [lane_w-1:0] pin_wdata;
  logic [lane_w-1:0] pin_rdata;
  logic              pin_strobe;
  logic              pin_rw;
  logic              pin_oe;

  int unsigned error_count;
  int unsigned check_count;
  int unsigned cycle_count;

  // External byte device model
  bus_word_t dev_mem [16];  // Indexed by word address bits 5:2
  int        beat_idx;      // Strobes seen so far in the current frame
  int        strobe_total;
  int        frame_count;
  int        frame_strobes;  // Length of the last finished frame
  int        frame_rw_cnt;
  int        frame_oe_cnt;
  logic      frame_rw;
  bus_word_t frame_addr;
  bus_word_t frame_wdata;

  pin_bus_bridge i_pin_bus_bridge (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pready     (pready),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .pin_addr   (pin_addr),
    .pin_wdata  (pin_wdata),
    .pin_rdata  (pin_rdata),
    .pin_strobe (pin_strobe),
    .pin_rw     (pin_rw),
    .pin_oe     (pin_oe)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             i_pin_bus_bridge.i_pin_bus_bridge_assertions.fail_count);
    $display("test failed");
    $finish;
  end

  // Device follows each beat just after the clock edge that starts it
  initial begin
    pin_rdata     = '0;
    beat_idx      = 0;
    strobe_total  = 0;
    frame_count   = 0;
    frame_strobes = 0;
    frame_rw_cnt  = 0;
    frame_oe_cnt  = 0;
    frame_rw      = 1'b0;
    frame_addr    = '0;
    frame_wdata   = '0;
    forever begin
      @(posedge clk);
      #1;
      if (pin_strobe) begin
        if (beat_idx == 0) begin
          frame_rw     = pin_rw;  // New frame
          frame_rw_cnt = 0;
          frame_oe_cnt = 0;
        end
        if (pin_rw) begin
          frame_rw_cnt++;
        end
        if (pin_oe) begin
          frame_oe_cnt++;
        end
        if (beat_idx < beats) begin
          frame_addr[lane_w*beat_idx +: lane_w]  = pin_addr;   // LSB first
          frame_wdata[lane_w*beat_idx +: lane_w] = pin_wdata;
          pin_rdata = '0;
        end else if (beat_idx < 2 * beats) begin
          // Read beat, byte held until the edge that ends it
          pin_rdata = dev_mem[frame_addr[5:2]][lane_w*(beat_idx-beats) +: lane_w];
        end else begin
          pin_rdata = '0;
        end
        beat_idx++;
        strobe_total++;
      end else begin
        pin_rdata = '0;
        if (beat_idx != 0) begin
          frame_strobes = beat_idx;
          frame_count++;
          if (frame_rw && (beat_idx == beats)) begin
            dev_mem[frame_addr[5:2]] = frame_wdata;
          end
          beat_idx = 0;
        end
      end
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic bus_word_t fill_word(input int idx);
    return (idx * 32'h1f3d_5b79) ^ 32'h8421_7e5a;
  endfunction

  // One APB transfer, entered just after a rising edge
  task automatic run_transfer(input logic write, input bus_word_t addr, input bus_word_t wdata,
                              output bus_word_t rdata, output logic err, output int edges);
    logic seen;
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    edges   = 0;
    seen    = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    while (!seen && (edges < wait_limit)) begin
      @(posedge clk);
      #1;
      edges++;
      if (pready) begin
        seen  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end
    end
    if (!seen) begin
      error_count++;
      $display("No pready within %0d cycles of the access phase at %0t", wait_limit, $time);
    end
    @(posedge clk);  // Host sees pready at this edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input bus_word_t addr, input bus_word_t data,
                           output logic err, output int edges);
    bus_word_t unused;
    run_transfer(1'b1, addr, data, unused, err, edges);
  endtask

  task automatic apb_read(input bus_word_t addr, output bus_word_t data,
                          output logic err, output int edges);
    run_transfer(1'b0, addr, '0, data, err, edges);
  endtask

  task automatic check_reset_state();
    check_value("pready after reset", pready, 0);
    check_value("pslverr after reset", pslverr, 0);
    check_value("pin_strobe after reset", pin_strobe, 0);
    check_value("pin_oe after reset", pin_oe, 0);
    check_value("pin_addr after reset", pin_addr, 0);
    check_value("pin_wdata after reset", pin_wdata, 0);
  endtask

  task automatic write_framing();
    bus_word_t addr;
    bus_word_t data;
    logic      err;
    int        edges;
    int        frames;
    for (int n = 0; n < 4; n++) begin
      addr   = $urandom() & 32'hffff_fffc;
      data   = $urandom();
      frames = frame_count;
      apb_write(addr, data, err, edges);
      check_value("write pslverr", err, 0);
      check_value("write completion edge", edges, 1 + beats);  // E5
      check_value("write frames", frame_count, frames + 1);
      check_value("write strobes", frame_strobes, beats);
      check_value("write beats with pin_rw", frame_rw_cnt, beats);
      check_value("write beats with pin_oe", frame_oe_cnt, beats);
      check_value("write address bytes", frame_addr, addr);
      check_value("write data bytes", frame_wdata, data);
      check_value("device word after write", dev_mem[addr[5:2]], data);
    end
  endtask

  task automatic read_path();
    bus_word_t addr;
    bus_word_t rdata;
    logic      err;
    int        edges;
    int        frames;
    int        idx;
    for (int i = 0; i < 16; i++) begin
      dev_mem[i] = fill_word(i);
    end
    for (int n = 0; n < 4; n++) begin
      idx    = $urandom_range(15, 0);
      addr   = ($urandom() & 32'hffff_ffc0) | (idx << 2);
      frames = frame_count;
      apb_read(addr, rdata, err, edges);
      check_value("read pslverr", err, 0);
      check_value("read completion edge", edges, 1 + 2 * beats);  // E9
      check_value("read frames", frame_count, frames + 1);
      check_value("read strobes", frame_strobes, 2 * beats);
      check_value("read beats with pin_oe", frame_oe_cnt, 0);
      check_value("read beats with pin_rw", frame_rw_cnt, 0);
      check_value("read address bytes", frame_addr, addr);
      check_value("prdata", rdata, fill_word(idx));
    end
  endtask

  task automatic write_read_back();
    bus_word_t addrs [6];
    bus_word_t datas [6];
    bus_word_t rdata;
    logic      err;
    int        edges;
    int        start;
    start = $urandom_range(15, 0);
    for (int k = 0; k < 6; k++) begin
      // Stride 5 keeps the six word indices distinct
      addrs[k] = ($urandom() & 32'hffff_ffc0) | (((start + 5 * k) % 16) << 2);
      datas[k] = $urandom();
      apb_write(addrs[k], datas[k], err, edges);
      check_value("write-back pslverr", err, 0);
    end
    for (int k = 5; k >= 0; k--) begin
      apb_read(addrs[k], rdata, err, edges);
      check_value("read-back pslverr", err, 0);
      check_value("read-back data", rdata, datas[k]);
    end
  endtask

  task automatic unaligned_access();
    bus_word_t addr;
    bus_word_t rdata;
    logic      err;
    int        edges;
    int        strobes;
    for (int off = 1; off < 4; off++) begin
      addr    = ($urandom() & 32'hffff_fffc) | off;
      strobes = strobe_total;
      apb_write(addr, $urandom(), err, edges);
      check_value("unaligned write pslverr", err, 1);
      check_value("unaligned write completion edge", edges, 1);
      check_value("strobes on unaligned write", strobe_total, strobes);
      strobes = strobe_total;
      apb_read(addr, rdata, err, edges);
      check_value("unaligned read pslverr", err, 1);
      check_value("unaligned read completion edge", edges, 1);
      check_value("strobes on unaligned read", strobe_total, strobes);
    end
  endtask

  initial begin
    int unsigned total;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h54fb));
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_state();
    write_framing();
    read_path();
    write_read_back();
    unaligned_access();
    repeat (2) @(posedge clk);
    #1;
    total = error_count + i_pin_bus_bridge.i_pin_bus_bridge_assertions.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             i_pin_bus_bridge.i_pin_bus_bridge_assertions.fail_count);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
